/* design/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;
    localparam int ILEN = 32;

    // Major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        LOAD     = 5'b00000,
        MISC_MEM = 5'b00011,
        OP_IMM   = 5'b00100,
        AUIPC    = 5'b00101,
        STORE    = 5'b01000,
        OP       = 5'b01100,
        LUI      = 5'b01101,
        BRANCH   = 5'b11000,
        JALR     = 5'b11001,
        JAL      = 5'b11011,
        SYSTEM   = 5'b11100
    } opcode_e;

    localparam logic [2:0] F3_LB   = 3'b000;
    localparam logic [2:0] F3_LH   = 3'b001;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_LBU  = 3'b100;
    localparam logic [2:0] F3_LHU  = 3'b101;

    localparam logic [2:0] F3_SB   = 3'b000;
    localparam logic [2:0] F3_SH   = 3'b001;
    localparam logic [2:0] F3_SW   = 3'b010;

    // Shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    // Marks SUB, SRA and SRAI
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

/* design/dec_ctrl_pkg.sv */
`default_nettype none

package dec_ctrl_pkg;

    localparam int LANES     = 2;
    localparam int MEM_BYTES = 4;

    // Byte enables for byte, halfword and word accesses
    localparam logic [MEM_BYTES-1:0] BYTE_EN_B = 4'b0001;
    localparam logic [MEM_BYTES-1:0] BYTE_EN_H = 4'b0011;
    localparam logic [MEM_BYTES-1:0] BYTE_EN_W = 4'b1111;

    // ADD sits at zero so that a cleared control word selects it
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef struct packed {
        logic                          slot_valid;
        logic                          ill_inst;
        logic [rv_isa_pkg::XLEN-1:0]   imm;
        alu_op_e                       alu_op;
        logic                          rs1_zero_sel;
        logic                          rs2_imm_sel;
        logic                          pc_imm_sel;
        logic                          branch;
        logic                          branch_zcmp;
        logic                          jump;
        logic                          jump_alu;
        logic                          pc_alu_sel;
        logic                          mem_req;
        logic                          mem_wr;
        logic [MEM_BYTES-1:0]          mem_byte;
        logic                          mem_sign_ext;
        logic                          mem_cal_sel;
        logic                          reg_wr;
    } dec_ctrl_t;

    typedef struct packed {
        logic [LANES-1:0][rv_isa_pkg::ILEN-1:0] inst;
        logic [LANES-1:0]                       valid;
    } fetch_bundle_t;

    typedef dec_ctrl_t [LANES-1:0] dec_bundle_t;

endpackage

`default_nettype wire

/* design/dec_lane.sv */
`default_nettype none

module dec_lane (
    input  wire logic                        slot_valid_i,
    input  wire logic [rv_isa_pkg::ILEN-1:0] inst_i,
    output dec_ctrl_pkg::dec_ctrl_t          ctrl_o
);

    logic [rv_isa_pkg::XLEN-1:0] imm_i;
    logic [rv_isa_pkg::XLEN-1:0] imm_s;
    logic [rv_isa_pkg::XLEN-1:0] imm_b;
    logic [rv_isa_pkg::XLEN-1:0] imm_u;
    logic [rv_isa_pkg::XLEN-1:0] imm_j;
    rv_isa_pkg::opcode_e         opcode;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    logic                        f7_base;
    logic                        f7_alt;
    dec_ctrl_pkg::dec_ctrl_t     dec;
    logic                        illegal;

    assign imm_i = {{21{inst_i[31]}}, inst_i[30:20]};
    assign imm_s = {{21{inst_i[31]}}, inst_i[30:25], inst_i[11:7]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    assign opcode  = rv_isa_pkg::opcode_e'(inst_i[6:2]);
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign f7_base = (funct7 == rv_isa_pkg::FUNCT7_BASE);
    assign f7_alt  = (funct7 == rv_isa_pkg::FUNCT7_ALT);

    always_comb begin
        dec     = '0;
        illegal = (inst_i[1:0] != 2'b11);
        case (opcode)
            rv_isa_pkg::LOAD: begin
                dec.imm          = imm_i;
                dec.alu_op       = dec_ctrl_pkg::ALU_ADD;
                dec.rs1_zero_sel = 1'b1;
                dec.mem_req      = 1'b1;
                dec.mem_cal_sel  = 1'b1;
                dec.reg_wr       = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_LB: begin
                        dec.mem_byte     = dec_ctrl_pkg::BYTE_EN_B;
                        dec.mem_sign_ext = 1'b1;
                    end
                    rv_isa_pkg::F3_LH: begin
                        dec.mem_byte     = dec_ctrl_pkg::BYTE_EN_H;
                        dec.mem_sign_ext = 1'b1;
                    end
                    rv_isa_pkg::F3_LW: begin
                        dec.mem_byte     = dec_ctrl_pkg::BYTE_EN_W;
                        dec.mem_sign_ext = 1'b1;
                    end
                    rv_isa_pkg::F3_LBU: dec.mem_byte = dec_ctrl_pkg::BYTE_EN_B;
                    rv_isa_pkg::F3_LHU: dec.mem_byte = dec_ctrl_pkg::BYTE_EN_H;
                    default:            illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::STORE: begin
                dec.imm          = imm_s;
                dec.alu_op       = dec_ctrl_pkg::ALU_ADD;
                dec.rs1_zero_sel = 1'b1;
                dec.mem_req      = 1'b1;
                dec.mem_wr       = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_SB: dec.mem_byte = dec_ctrl_pkg::BYTE_EN_B;
                    rv_isa_pkg::F3_SH: dec.mem_byte = dec_ctrl_pkg::BYTE_EN_H;
                    rv_isa_pkg::F3_SW: dec.mem_byte = dec_ctrl_pkg::BYTE_EN_W;
                    default:           illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::OP_IMM, rv_isa_pkg::OP: begin
                dec.rs1_zero_sel = 1'b1;
                dec.reg_wr       = 1'b1;
                if (opcode == rv_isa_pkg::OP) begin
                    dec.rs2_imm_sel = 1'b1;
                end else begin
                    dec.imm = imm_i;
                end
                case (funct3)
                    rv_isa_pkg::F3_ADD: begin
                        // Immediate forms carry no funct7, so SUB exists only in OP
                        if (opcode == rv_isa_pkg::OP && f7_alt) begin
                            dec.alu_op = dec_ctrl_pkg::ALU_SUB;
                        end else begin
                            dec.alu_op = dec_ctrl_pkg::ALU_ADD;
                        end
                    end
                    rv_isa_pkg::F3_SLL:  dec.alu_op = dec_ctrl_pkg::ALU_SLL;
                    rv_isa_pkg::F3_SLT:  dec.alu_op = dec_ctrl_pkg::ALU_SLT;
                    rv_isa_pkg::F3_SLTU: dec.alu_op = dec_ctrl_pkg::ALU_SLTU;
                    rv_isa_pkg::F3_XOR:  dec.alu_op = dec_ctrl_pkg::ALU_XOR;
                    rv_isa_pkg::F3_SRL: begin
                        dec.alu_op = f7_alt ? dec_ctrl_pkg::ALU_SRA : dec_ctrl_pkg::ALU_SRL;
                    end
                    rv_isa_pkg::F3_OR:   dec.alu_op = dec_ctrl_pkg::ALU_OR;
                    default:             dec.alu_op = dec_ctrl_pkg::ALU_AND;
                endcase
                // OP checks funct7 on every funct3, OP-IMM only on the shifts
                if (opcode == rv_isa_pkg::OP || funct3 == rv_isa_pkg::F3_SLL ||
                    funct3 == rv_isa_pkg::F3_SRL) begin
                    if (!(f7_base || (f7_alt && (funct3 == rv_isa_pkg::F3_SRL ||
                          (opcode == rv_isa_pkg::OP && funct3 == rv_isa_pkg::F3_ADD))))) begin
                        illegal = 1'b1;
                    end
                end
            end
            rv_isa_pkg::LUI: begin
                dec.imm    = imm_u;
                dec.alu_op = dec_ctrl_pkg::ALU_OR;
                dec.reg_wr = 1'b1;
            end
            rv_isa_pkg::AUIPC: begin
                dec.imm          = imm_u;
                dec.alu_op       = dec_ctrl_pkg::ALU_ADD;
                dec.rs1_zero_sel = 1'b1;
                dec.pc_imm_sel   = 1'b1;
                dec.pc_alu_sel   = 1'b1;
                dec.reg_wr       = 1'b1;
            end
            rv_isa_pkg::BRANCH: begin
                dec.imm          = imm_b;
                dec.rs1_zero_sel = 1'b1;
                dec.rs2_imm_sel  = 1'b1;
                dec.branch       = 1'b1;
                // zcmp set means the branch is taken when the ALU result is zero
                case (funct3)
                    rv_isa_pkg::F3_BEQ: begin
                        dec.alu_op      = dec_ctrl_pkg::ALU_SUB;
                        dec.branch_zcmp = 1'b1;
                    end
                    rv_isa_pkg::F3_BNE: dec.alu_op = dec_ctrl_pkg::ALU_SUB;
                    rv_isa_pkg::F3_BLT: dec.alu_op = dec_ctrl_pkg::ALU_SLT;
                    rv_isa_pkg::F3_BGE: begin
                        dec.alu_op      = dec_ctrl_pkg::ALU_SLT;
                        dec.branch_zcmp = 1'b1;
                    end
                    rv_isa_pkg::F3_BLTU: dec.alu_op = dec_ctrl_pkg::ALU_SLTU;
                    rv_isa_pkg::F3_BGEU: begin
                        dec.alu_op      = dec_ctrl_pkg::ALU_SLTU;
                        dec.branch_zcmp = 1'b1;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::JALR: begin
                dec.imm          = imm_i;
                dec.alu_op       = dec_ctrl_pkg::ALU_ADD;
                dec.rs1_zero_sel = 1'b1;
                dec.pc_alu_sel   = 1'b1;
                dec.reg_wr       = 1'b1;
                dec.jump_alu     = 1'b1;
                if (funct3 != rv_isa_pkg::F3_JALR) begin
                    illegal = 1'b1;
                end
            end
            rv_isa_pkg::JAL: begin
                dec.imm          = imm_j;
                dec.rs1_zero_sel = 1'b1;
                dec.rs2_imm_sel  = 1'b1;
                dec.pc_alu_sel   = 1'b1;
                dec.reg_wr       = 1'b1;
                dec.jump         = 1'b1;
            end
            // SYSTEM, MISC-MEM and all remaining opcodes are not supported
            default: illegal = 1'b1;
        endcase
    end

    always_comb begin
        ctrl_o = '0;
        if (slot_valid_i) begin
            if (!illegal) begin
                ctrl_o = dec;
            end
            ctrl_o.slot_valid = 1'b1;
            ctrl_o.ill_inst   = illegal;
        end
    end

    ill_blocks_side_effects: assert final (!ctrl_o.ill_inst || !(ctrl_o.reg_wr || ctrl_o.mem_req))
        else $error("illegal instruction still requests a write or memory access");

endmodule

`default_nettype wire

/* design/dec_bundle_in.sv */
`default_nettype none

module dec_bundle_in (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,
    input  wire logic                        fetch_valid_i,
    input  wire dec_ctrl_pkg::fetch_bundle_t fetch_bundle_i,
    output logic                             fetch_ready_o,
    input  wire logic                        stage_ready_i,
    output logic                             held_valid_o,
    output dec_ctrl_pkg::fetch_bundle_t      held_bundle_o
);

    // Free when empty or when the held bundle leaves on this edge
    assign fetch_ready_o = !held_valid_o || stage_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            held_valid_o <= 1'b0;
        end else if (fetch_ready_o) begin
            held_valid_o <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_valid_i && fetch_ready_o) begin
            held_bundle_o <= fetch_bundle_i;
        end
    end

    property p_held_while_stalled;
        @(posedge clk_i) disable iff (!rst_n_i)
        held_valid_o && !stage_ready_i |=> held_valid_o && $stable(held_bundle_o);
    endproperty

    held_stable_a: assert property (p_held_while_stalled)
        else $error("input bundle changed while the decode stage was stalled");

endmodule

`default_nettype wire

/* design/dec_bundle_out.sv */
`default_nettype none

module dec_bundle_out (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    input  wire logic                      load_valid_i,
    input  wire dec_ctrl_pkg::dec_bundle_t load_bundle_i,
    output logic                           stage_ready_o,
    output logic                           dec_valid_o,
    output dec_ctrl_pkg::dec_bundle_t      dec_bundle_o,
    input  wire logic                      dec_ready_i
);

    assign stage_ready_o = !dec_valid_o || dec_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else if (stage_ready_o) begin
            dec_valid_o <= load_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_valid_i && stage_ready_o) begin
            dec_bundle_o <= load_bundle_i;
        end
    end

    property p_out_while_stalled;
        @(posedge clk_i) disable iff (!rst_n_i)
        dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_bundle_o);
    endproperty

    out_stable_a: assert property (p_out_while_stalled)
        else $error("decoded bundle changed while execute held ready low");

endmodule

`default_nettype wire

/* design/dec_top.sv */
`default_nettype none

module dec_top (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,
    input  wire logic                        fetch_valid_i,
    input  wire dec_ctrl_pkg::fetch_bundle_t fetch_bundle_i,
    output wire logic                        fetch_ready_o,
    output wire logic                        dec_valid_o,
    output wire dec_ctrl_pkg::dec_bundle_t   dec_bundle_o,
    input  wire logic                        dec_ready_i
);

    wire logic                        held_valid;
    wire dec_ctrl_pkg::fetch_bundle_t held_bundle;
    wire logic                        stage_ready;
    wire dec_ctrl_pkg::dec_bundle_t   lane_bundle;

    dec_bundle_in bundle_in_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_bundle_i (fetch_bundle_i),
        .fetch_ready_o  (fetch_ready_o),
        .stage_ready_i  (stage_ready),
        .held_valid_o   (held_valid),
        .held_bundle_o  (held_bundle)
    );

    // One decoder per slot, all working on the same held bundle
    for (genvar k = 0; k < dec_ctrl_pkg::LANES; k++) begin : g_lane
        dec_lane lane_i (
            .slot_valid_i (held_bundle.valid[k]),
            .inst_i       (held_bundle.inst[k]),
            .ctrl_o       (lane_bundle[k])
        );
    end

    dec_bundle_out bundle_out_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .load_valid_i  (held_valid),
        .load_bundle_i (lane_bundle),
        .stage_ready_o (stage_ready),
        .dec_valid_o   (dec_valid_o),
        .dec_bundle_o  (dec_bundle_o),
        .dec_ready_i   (dec_ready_i)
    );

endmodule

`default_nettype wire

/* tests/tb_dec_ref.svh */
`ifndef TB_DEC_REF_SVH
`define TB_DEC_REF_SVH

// The nine major opcodes that the stage decodes, element 0 first
localparam logic [8:0][4:0] KEPT_OPC = {
    rv_isa_pkg::JAL, rv_isa_pkg::JALR, rv_isa_pkg::BRANCH,
    rv_isa_pkg::AUIPC, rv_isa_pkg::LUI, rv_isa_pkg::OP,
    rv_isa_pkg::OP_IMM, rv_isa_pkg::STORE, rv_isa_pkg::LOAD
};

// Right-shift Galois LFSR for x^32 + x^31 + x^29 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'hd000_0001;
    end
    return state >> 1;
endfunction

// Instruction template with random fields under a fixed opcode and funct3
// f7_sel 0 keeps the random top bits, 1 forces BASE, 2 forces ALT
function automatic logic [31:0] make_inst(input logic [4:0] opc, input logic [2:0] f3,
                                          input logic [1:0] f7_sel, input logic [31:0] rnd);
    logic [31:0] inst;
    inst        = rnd;
    inst[6:0]   = {opc, 2'b11};
    inst[14:12] = f3;
    if (f7_sel == 2'd1) begin
        inst[31:25] = rv_isa_pkg::FUNCT7_BASE;
    end else if (f7_sel == 2'd2) begin
        inst[31:25] = rv_isa_pkg::FUNCT7_ALT;
    end
    return inst;
endfunction

// Byte enables from the access size in funct3[1:0]
function automatic logic [dec_ctrl_pkg::MEM_BYTES-1:0] size_mask(input logic [1:0] size);
    case (size)
        2'd0:    return 4'b0001;
        2'd1:    return 4'b0011;
        2'd2:    return 4'b1111;
        default: return 4'b0000;
    endcase
endfunction

function automatic dec_ctrl_pkg::dec_ctrl_t ref_decode(input logic valid,
                                                       input logic [31:0] inst);
    dec_ctrl_pkg::dec_ctrl_t c;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       is_op;
    logic       f7_ok;
    logic       bad;
    c     = '0;
    f3    = inst[14:12];
    f7    = inst[31:25];
    is_op = (inst[6:2] == rv_isa_pkg::OP);
    bad   = (inst[1:0] != 2'b11);
    case (inst[6:2])
        rv_isa_pkg::LOAD: begin
            c.imm          = {{20{inst[31]}}, inst[31:20]};
            c.alu_op       = dec_ctrl_pkg::ALU_ADD;
            c.rs1_zero_sel = 1'b1;
            c.mem_req      = 1'b1;
            c.mem_cal_sel  = 1'b1;
            c.reg_wr       = 1'b1;
            c.mem_byte     = size_mask(f3[1:0]);
            c.mem_sign_ext = !f3[2];
            bad = bad || f3[1:0] == 2'b11 || f3[2:1] == 2'b11;
        end
        rv_isa_pkg::STORE: begin
            c.imm          = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            c.alu_op       = dec_ctrl_pkg::ALU_ADD;
            c.rs1_zero_sel = 1'b1;
            c.mem_req      = 1'b1;
            c.mem_wr       = 1'b1;
            c.mem_byte     = size_mask(f3[1:0]);
            bad = bad || f3[2] || f3[1:0] == 2'b11;
        end
        rv_isa_pkg::OP_IMM, rv_isa_pkg::OP: begin
            c.imm          = is_op ? '0 : {{20{inst[31]}}, inst[31:20]};
            c.rs1_zero_sel = 1'b1;
            c.rs2_imm_sel  = is_op;
            c.reg_wr       = 1'b1;
            case (f3)
                3'd0: c.alu_op = (is_op && f7 == rv_isa_pkg::FUNCT7_ALT) ?
                                 dec_ctrl_pkg::ALU_SUB : dec_ctrl_pkg::ALU_ADD;
                3'd1: c.alu_op = dec_ctrl_pkg::ALU_SLL;
                3'd2: c.alu_op = dec_ctrl_pkg::ALU_SLT;
                3'd3: c.alu_op = dec_ctrl_pkg::ALU_SLTU;
                3'd4: c.alu_op = dec_ctrl_pkg::ALU_XOR;
                3'd5: c.alu_op = (f7 == rv_isa_pkg::FUNCT7_ALT) ?
                                 dec_ctrl_pkg::ALU_SRA : dec_ctrl_pkg::ALU_SRL;
                3'd6: c.alu_op = dec_ctrl_pkg::ALU_OR;
                default: c.alu_op = dec_ctrl_pkg::ALU_AND;
            endcase
            // ALT is allowed for SRL/SRA and for SUB in the register form only
            f7_ok = (f7 == rv_isa_pkg::FUNCT7_BASE) || (f7 == rv_isa_pkg::FUNCT7_ALT &&
                    (f3 == 3'd5 || (is_op && f3 == 3'd0)));
            bad = bad || ((is_op || f3 == 3'd1 || f3 == 3'd5) && !f7_ok);
        end
        rv_isa_pkg::LUI: begin
            c.imm    = {inst[31:12], 12'h000};
            c.alu_op = dec_ctrl_pkg::ALU_OR;
            c.reg_wr = 1'b1;
        end
        rv_isa_pkg::AUIPC: begin
            c.imm          = {inst[31:12], 12'h000};
            c.alu_op       = dec_ctrl_pkg::ALU_ADD;
            c.rs1_zero_sel = 1'b1;
            c.pc_imm_sel   = 1'b1;
            c.pc_alu_sel   = 1'b1;
            c.reg_wr       = 1'b1;
        end
        rv_isa_pkg::BRANCH: begin
            c.imm          = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            c.rs1_zero_sel = 1'b1;
            c.rs2_imm_sel  = 1'b1;
            c.branch       = 1'b1;
            if (!f3[2]) begin
                c.alu_op = dec_ctrl_pkg::ALU_SUB;
            end else if (!f3[1]) begin
                c.alu_op = dec_ctrl_pkg::ALU_SLT;
            end else begin
                c.alu_op = dec_ctrl_pkg::ALU_SLTU;
            end
            // BEQ, BGE and BGEU are taken on a zero ALU result
            c.branch_zcmp = (f3 == 3'd0) || (f3[2] && f3[0]);
            bad = bad || f3[2:1] == 2'b01;
        end
        rv_isa_pkg::JALR: begin
            c.imm          = {{20{inst[31]}}, inst[31:20]};
            c.alu_op       = dec_ctrl_pkg::ALU_ADD;
            c.rs1_zero_sel = 1'b1;
            c.pc_alu_sel   = 1'b1;
            c.reg_wr       = 1'b1;
            c.jump_alu     = 1'b1;
            bad = bad || f3 != 3'd0;
        end
        rv_isa_pkg::JAL: begin
            c.imm          = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            c.rs1_zero_sel = 1'b1;
            c.rs2_imm_sel  = 1'b1;
            c.pc_alu_sel   = 1'b1;
            c.reg_wr       = 1'b1;
            c.jump         = 1'b1;
        end
        default: bad = 1'b1;
    endcase
    if (!valid) begin
        return '0;
    end
    if (bad) begin
        c          = '0;
        c.ill_inst = 1'b1;
    end
    c.slot_valid = 1'b1;
    return c;
endfunction

`endif

/* tests/tb_dec_top.sv */
`default_nettype none

module tb_dec_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SWEEP_SLOTS     = 9 * 8 * 3;
    localparam int ILLEGAL_SLOTS   = 32 * 4;
    localparam int SLOT_BUNDLES    = 40;
    localparam int BP_BUNDLES      = 200;
    localparam int RATE_BUNDLES    = 40;
    localparam int TOTAL_BUNDLES   = SWEEP_SLOTS / dec_ctrl_pkg::LANES +
                                     ILLEGAL_SLOTS / dec_ctrl_pkg::LANES +
                                     SLOT_BUNDLES + BP_BUNDLES + RATE_BUNDLES;
    localparam int CYCLE_LIMIT     = 2 * TOTAL_BUNDLES + 200;

    logic                        clk_i;
    logic                        rst_n_i;
    logic                        fetch_valid_i;
    dec_ctrl_pkg::fetch_bundle_t fetch_bundle_i;
    logic                        fetch_ready_o;
    logic                        dec_valid_o;
    dec_ctrl_pkg::dec_bundle_t   dec_bundle_o;
    logic                        dec_ready_i;

    logic [31:0]               lfsr_q = 32'hc3f07b05;
    dec_ctrl_pkg::dec_bundle_t exp_q[$];
    string                     test_name = "reset_state";
    logic                      rand_ready = 1'b0;
    int                        err_count = 0;
    int                        check_count = 0;
    int                        test_count = 0;
    int                        sent_count = 0;
    int                        stall_count = 0;
    int                        cycle_count = 0;
    int                        test_err0 = 0;
    int                        test_sent0 = 0;

    `include "tb_dec_ref.svh"

    dec_top dec_top_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_bundle_i (fetch_bundle_i),
        .fetch_ready_o  (fetch_ready_o),
        .dec_valid_o    (dec_valid_o),
        .dec_bundle_o   (dec_bundle_o),
        .dec_ready_i    (dec_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin : watchdog
        wait (cycle_count > CYCLE_LIMIT);
        $display("TIMEOUT: the run did not end within %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    // One output bit per LFSR step
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return r;
    endfunction

    function automatic dec_ctrl_pkg::fetch_bundle_t random_bundle();
        dec_ctrl_pkg::fetch_bundle_t b;
        logic [4:0]                  opc;
        logic [2:0]                  f3;
        logic [1:0]                  f7_sel;
        for (int k = 0; k < dec_ctrl_pkg::LANES; k++) begin
            opc       = KEPT_OPC[rand_bits(4) % 9];
            f3        = 3'(rand_bits(3));
            f7_sel    = 2'(rand_bits(2) % 3);
            b.inst[k] = make_inst(opc, f3, f7_sel, rand_bits(32));
        end
        b.valid = dec_ctrl_pkg::LANES'(rand_bits(dec_ctrl_pkg::LANES));
        return b;
    endfunction

    task automatic check_ctrl(input string what, input dec_ctrl_pkg::dec_ctrl_t exp,
                              input dec_ctrl_pkg::dec_ctrl_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("CHECK FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        if (rand_ready) begin
            dec_ready_i = (rand_bits(1) != 0);
        end
    endtask

    // Holds the bundle on the fetch side until the stage takes it
    task automatic send_bundle(input dec_ctrl_pkg::fetch_bundle_t b);
        dec_ctrl_pkg::dec_bundle_t e;
        for (int k = 0; k < dec_ctrl_pkg::LANES; k++) begin
            e[k] = ref_decode(b.valid[k], b.inst[k]);
        end
        fetch_valid_i  = 1'b1;
        fetch_bundle_i = b;
        @(negedge clk_i);
        while (!fetch_ready_o) begin
            stall_count++;
            next_cycle();
            @(negedge clk_i);
        end
        exp_q.push_back(e);
        sent_count++;
        next_cycle();
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_err0  = err_count;
        test_sent0 = sent_count;
    endtask

    task automatic finish_test();
        fetch_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        rand_ready  = 1'b0;
        dec_ready_i = 1'b1;
        test_count++;
        $display("test %-18s %4d bundles %4d errors", test_name,
                 sent_count - test_sent0, err_count - test_err0);
    endtask

    // Sampled at the falling edge, where DUT outputs and TB inputs are both settled
    initial begin : compare
        dec_ctrl_pkg::dec_bundle_t exp;
        dec_ctrl_pkg::dec_bundle_t held;
        logic                      stalled;
        int                        in_flight;
        stalled   = 1'b0;
        held      = '0;
        in_flight = 0;
        forever begin
            @(negedge clk_i);
            if (rst_n_i) begin
                // The stage holds two bundles and takes another only as one leaves
                check_flag("fetch_ready_o", in_flight < 2 || dec_ready_i, fetch_ready_o);
                if (stalled) begin
                    for (int k = 0; k < dec_ctrl_pkg::LANES; k++) begin
                        check_ctrl($sformatf("lane %0d held under stall", k), held[k],
                                   dec_bundle_o[k]);
                    end
                end
                if (dec_valid_o && dec_ready_i) begin
                    if (exp_q.size() == 0) begin
                        err_count++;
                        $display("ERROR in %s: a bundle left the stage with none outstanding",
                                 test_name);
                    end else begin
                        exp = exp_q.pop_front();
                        for (int k = 0; k < dec_ctrl_pkg::LANES; k++) begin
                            check_ctrl($sformatf("lane %0d", k), exp[k], dec_bundle_o[k]);
                        end
                    end
                end
                if (fetch_valid_i && fetch_ready_o) begin
                    in_flight++;
                end
                if (dec_valid_o && dec_ready_i) begin
                    in_flight--;
                end
                stalled = dec_valid_o && !dec_ready_i;
                held    = dec_bundle_o;
            end
        end
    end

    initial begin : stimulus
        dec_ctrl_pkg::fetch_bundle_t b;
        int                          t;
        int                          stalls0;
        rst_n_i        = 1'b0;
        fetch_valid_i  = 1'b0;
        fetch_bundle_i = '0;
        dec_ready_i    = 1'b1;

        start_test("reset_state");
        repeat (8) @(posedge clk_i);
        #1;
        check_flag("dec_valid_o in reset", 1'b0, dec_valid_o);
        check_flag("fetch_ready_o in reset", 1'b1, fetch_ready_o);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_flag("dec_valid_o after reset", 1'b0, dec_valid_o);
        check_flag("fetch_ready_o after reset", 1'b1, fetch_ready_o);
        next_cycle();
        finish_test();

        // Every kept opcode with every funct3, and funct7 as BASE, ALT or random
        start_test("legal_classes");
        for (int n = 0; n < SWEEP_SLOTS; n += dec_ctrl_pkg::LANES) begin
            for (int k = 0; k < dec_ctrl_pkg::LANES; k++) begin
                t         = n + k;
                b.inst[k] = make_inst(KEPT_OPC[t / 24], 3'((t / 3) % 8), 2'(t % 3),
                                      rand_bits(32));
            end
            b.valid = '1;
            send_bundle(b);
        end
        finish_test();

        // All 32 major opcodes crossed with all four low-bit values
        start_test("illegal_encodings");
        for (int n = 0; n < ILLEGAL_SLOTS; n += dec_ctrl_pkg::LANES) begin
            for (int k = 0; k < dec_ctrl_pkg::LANES; k++) begin
                t              = n + k;
                b.inst[k]      = rand_bits(32);
                b.inst[k][6:0] = {5'(t / 4), 2'(t % 4)};
            end
            b.valid = '1;
            send_bundle(b);
        end
        finish_test();

        start_test("slot_valids");
        for (int n = 0; n < SLOT_BUNDLES; n++) begin
            send_bundle(random_bundle());
        end
        finish_test();

        start_test("back_pressure");
        rand_ready = 1'b1;
        for (int n = 0; n < BP_BUNDLES; n++) begin
            if (rand_bits(2) == 0) begin
                fetch_valid_i = 1'b0;
                next_cycle();
            end
            b       = random_bundle();
            b.valid = '1;
            send_bundle(b);
        end
        finish_test();

        start_test("full_throughput");
        stalls0 = stall_count;
        for (int n = 0; n < RATE_BUNDLES; n++) begin
            send_bundle(random_bundle());
        end
        check_flag("bundle taken every cycle", 1'b1, stall_count == stalls0);
        finish_test();

        $display("%0d tests, %0d bundles, %0d checks, %0d errors",
                 test_count, sent_count, check_count, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+tests
design/rv_isa_pkg.sv
design/dec_ctrl_pkg.sv
design/dec_lane.sv
design/dec_bundle_in.sv
design/dec_bundle_out.sv
design/dec_top.sv
tests/tb_dec_top.sv
